// File: hdl/l2c_pkg.sv
//========================================
// l2c_pkg
// shared types and default widths for the
// layer-2 normal-loop controller
//========================================
package l2c_pkg;

    //========================================
    // layer and state encodings
    //========================================
    typedef enum logic [1:0] {
        POINTWISE = 2'd0,
        DEPTHWISE = 2'd1,
        STANDARD  = 2'd2,
        LINEAR    = 2'd3
    } layer_type_e;

    typedef enum logic [1:0] {
        IDLE,
        SET_NUM,       // one-cycle plan strobe
        WAIT_DONE,
        DONE           // done pulse
    } nl_state_e;

    //========================================
    // widths
    //========================================
    localparam int CNT_W_DEF = 16; // transfer count and descriptor fields

endpackage

// File: hdl/lane_cmd_if.sv
//========================================
// lane_cmd_if
// one lane's plan strobe and transfer counts
//========================================
`timescale 1ns/1ns

interface lane_cmd_if #(
    parameter int CNT_W = l2c_pkg::CNT_W_DEF
);
    logic             plan;       // load strobe, one cycle
    logic [CNT_W-1:0] ifmap_cnt;  // ifmap pops to issue
    logic [CNT_W-1:0] ipsum_cnt;  // ipsum pops to issue
    logic [CNT_W-1:0] opsum_cnt;  // opsum pushes to issue

    modport planner (
        output plan, ifmap_cnt, ipsum_cnt, opsum_cnt
    );

    modport lane (
        input plan, ifmap_cnt, ipsum_cnt, opsum_cnt
    );

endinterface

// File: hdl/lane_stat_if.sv
//========================================
// lane_stat_if
// one lane's transfer strobes and done level
//========================================
`timescale 1ns/1ns

interface lane_stat_if;
    logic ifmap_pop;   // ifmap fifo pop this cycle
    logic ipsum_pop;   // ipsum fifo pop this cycle
    logic opsum_push;  // opsum fifo push this cycle
    logic done;        // all counters drained

    modport lane (
        output ifmap_pop, ipsum_pop, opsum_push, done
    );

    modport gather (
        input ifmap_pop, ipsum_pop, opsum_push, done
    );

endinterface

// File: hdl/nl_planner.sv
//========================================
// nl_planner
// normal-loop FSM, turns a layer descriptor
// into per-lane transfer counts
//========================================
`timescale 1ns/1ns

module nl_planner #(
    parameter int NUM_LANES = 8,
    parameter int CNT_W     = l2c_pkg::CNT_W_DEF
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  l2c_pkg::layer_type_e  layer_type_i,
    input  logic [CNT_W-1:0]      tile_n_i,
    input  logic [CNT_W-1:0]      on_real_i,
    input  logic [CNT_W-1:0]      in_c_i,
    input  logic [1:0]            pad_r_i,
    input  logic [1:0]            pad_l_i,
    input  logic [CNT_W-1:0]      out_c_i,
    input  logic                  all_done_i,
    output logic                  done_o,
    lane_cmd_if.planner           cmd [NUM_LANES]
);

    localparam int GRP_LANES  = (NUM_LANES / 3) * 3; // lanes fed in groups of three
    localparam int PSUM_LANES = NUM_LANES / 3;       // one psum lane per group
    localparam logic [CNT_W+1:0] ONE     = 1;
    localparam logic [CNT_W+1:0] STD_OFF = 3;

    l2c_pkg::nl_state_e state_q, state_d;
    logic               plan;
    logic [CNT_W+1:0]   pad_w;  // input width with padding

    // a - b, floored at zero and capped at the count width
    function automatic logic [CNT_W-1:0] clamp_sub(input logic [CNT_W+1:0] a,
                                                   input logic [CNT_W+1:0] b);
        logic [CNT_W+1:0] diff;
        diff = a - b;
        if (a <= b)
            return '0;
        if (diff[CNT_W+1:CNT_W] != 2'b00)
            return '1;
        return diff[CNT_W-1:0];
    endfunction

    //========================================
    // state machine
    //========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= l2c_pkg::IDLE;
        else
            state_q <= state_d;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            l2c_pkg::IDLE:      if (start_i) state_d = l2c_pkg::SET_NUM;
            l2c_pkg::SET_NUM:   state_d = l2c_pkg::WAIT_DONE;
            l2c_pkg::WAIT_DONE: if (all_done_i) state_d = l2c_pkg::DONE;
            l2c_pkg::DONE:      state_d = l2c_pkg::IDLE;
            default:            state_d = l2c_pkg::IDLE;
        endcase
    end

    assign plan   = (state_q == l2c_pkg::SET_NUM);
    assign done_o = (state_q == l2c_pkg::DONE);
    assign pad_w  = {2'b00, in_c_i} + pad_r_i + pad_l_i;

    //========================================
    // per-lane counts by layer type
    //========================================
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        localparam logic [CNT_W+1:0] DW_OFF = 3 * (k / 3 + 1); // depthwise row skew

        logic [CNT_W-1:0] ifmap_cnt;
        logic [CNT_W-1:0] ipsum_cnt;
        logic [CNT_W-1:0] opsum_cnt;

        always_comb begin
            ifmap_cnt = '0;
            ipsum_cnt = '0;
            opsum_cnt = '0;
            if (plan) begin
                case (layer_type_i)
                    l2c_pkg::POINTWISE, l2c_pkg::LINEAR: begin
                        ifmap_cnt = clamp_sub({2'b00, tile_n_i}, ONE);
                        ipsum_cnt = (k == 0) ? clamp_sub({2'b00, on_real_i}, ONE) : on_real_i;
                        opsum_cnt = on_real_i;
                    end
                    l2c_pkg::DEPTHWISE, l2c_pkg::STANDARD: begin
                        if (k < GRP_LANES) begin
                            ifmap_cnt = clamp_sub(pad_w,
                                (layer_type_i == l2c_pkg::DEPTHWISE) ? DW_OFF : STD_OFF);
                        end
                        if (k < PSUM_LANES) begin
                            ipsum_cnt = (k == 0) ? clamp_sub({2'b00, on_real_i}, ONE)
                                                 : on_real_i;
                            opsum_cnt = out_c_i;
                        end
                    end
                    default: ; // unknown type loads nothing
                endcase
            end
        end

        assign cmd[k].plan      = plan;
        assign cmd[k].ifmap_cnt = ifmap_cnt;
        assign cmd[k].ipsum_cnt = ipsum_cnt;
        assign cmd[k].opsum_cnt = opsum_cnt;
    end

    //========================================
    // checks
    //========================================
    a_plan_single: assert property (@(posedge clk) disable iff (!rst_n)
        plan |=> !plan);

    a_type_known: assert property (@(posedge clk) disable iff (!rst_n)
        plan |-> !$isunknown(layer_type_i));

endmodule

// File: hdl/fifo_lane_ctrl.sv
//========================================
// fifo_lane_ctrl
// one lane's ifmap/ipsum/opsum down-counters
//========================================
`timescale 1ns/1ns

module fifo_lane_ctrl #(
    parameter int CNT_W = l2c_pkg::CNT_W_DEF
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ifmap_valid_i,  // ifmap fifo has data
    input  logic        ipsum_valid_i,  // ipsum fifo has data
    input  logic        opsum_ready_i,  // opsum fifo has room
    lane_cmd_if.lane    cmd,
    lane_stat_if.lane   stat,
    output logic        ifmap_pop_o,
    output logic        ipsum_pop_o,
    output logic        opsum_push_o
);

    logic [CNT_W-1:0] ifmap_q;
    logic [CNT_W-1:0] ipsum_q;
    logic [CNT_W-1:0] opsum_q;
    logic             ifmap_pop;
    logic             ipsum_pop;
    logic             opsum_push;
    logic             done;

    //========================================
    // transfer strobes
    //========================================
    assign ifmap_pop  = (ifmap_q != '0) && ifmap_valid_i;
    assign ipsum_pop  = (ipsum_q != '0) && ipsum_valid_i;
    assign opsum_push = (opsum_q != '0) && opsum_ready_i;
    assign done       = (ifmap_q == '0) && (ipsum_q == '0) && (opsum_q == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifmap_q <= '0;
            ipsum_q <= '0;
            opsum_q <= '0;
        end else if (cmd.plan) begin
            ifmap_q <= cmd.ifmap_cnt; // new plan wins
            ipsum_q <= cmd.ipsum_cnt;
            opsum_q <= cmd.opsum_cnt;
        end else begin
            if (ifmap_pop)
                ifmap_q <= ifmap_q - 1'b1;
            if (ipsum_pop)
                ipsum_q <= ipsum_q - 1'b1;
            if (opsum_push)
                opsum_q <= opsum_q - 1'b1;
        end
    end

    assign ifmap_pop_o     = ifmap_pop;
    assign ipsum_pop_o     = ipsum_pop;
    assign opsum_push_o    = opsum_push;
    assign stat.ifmap_pop  = ifmap_pop;
    assign stat.ipsum_pop  = ipsum_pop;
    assign stat.opsum_push = opsum_push;
    assign stat.done       = done;

    //========================================
    // checks
    //========================================
    a_quiet_when_done: assert property (@(posedge clk) disable iff (!rst_n)
        stat.done |-> !(ifmap_pop_o || ipsum_pop_o || opsum_push_o));

endmodule

// File: hdl/done_gather.sv
//========================================
// done_gather
// registered all-done and transfer total
//========================================
`timescale 1ns/1ns

module done_gather #(
    parameter int NUM_LANES = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          plan_i,       // new run, clears state
    lane_stat_if.gather   stat [NUM_LANES],
    output logic          all_done_o,
    output logic [31:0]   xfer_total_o
);

    logic [NUM_LANES-1:0] done_vec;
    logic [NUM_LANES-1:0] ifmap_vec;
    logic [NUM_LANES-1:0] ipsum_vec;
    logic [NUM_LANES-1:0] opsum_vec;
    logic [31:0]          step_sum;     // strobes this cycle
    logic                 all_done_q;
    logic [31:0]          total_q;

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_pick
        assign done_vec[k]  = stat[k].done;
        assign ifmap_vec[k] = stat[k].ifmap_pop;
        assign ipsum_vec[k] = stat[k].ipsum_pop;
        assign opsum_vec[k] = stat[k].opsum_push;
    end

    always_comb begin
        step_sum = '0;
        for (int k = 0; k < NUM_LANES; k++) begin
            step_sum = step_sum + ifmap_vec[k] + ipsum_vec[k] + opsum_vec[k];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            all_done_q <= 1'b0;
            total_q    <= '0;
        end else if (plan_i) begin
            all_done_q <= 1'b0; // lanes still loading
            total_q    <= '0;
        end else begin
            all_done_q <= &done_vec;
            total_q    <= total_q + step_sum;
        end
    end

    assign all_done_o   = all_done_q;
    assign xfer_total_o = total_q;

endmodule

// File: hdl/l2c_normal_loop_top.sv
//========================================
// l2c_normal_loop_top
// normal-loop stage: planner, fifo lanes
// and done gather
//========================================
`timescale 1ns/1ns

module l2c_normal_loop_top #(
    parameter int NUM_LANES = 8,
    parameter int CNT_W     = l2c_pkg::CNT_W_DEF
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  l2c_pkg::layer_type_e  layer_type_i,
    input  logic [CNT_W-1:0]      tile_n_i,
    input  logic [CNT_W-1:0]      on_real_i,
    input  logic [CNT_W-1:0]      in_c_i,
    input  logic [1:0]            pad_r_i,
    input  logic [1:0]            pad_l_i,
    input  logic [CNT_W-1:0]      out_c_i,
    input  logic [NUM_LANES-1:0]  ifmap_valid_i,
    input  logic [NUM_LANES-1:0]  ipsum_valid_i,
    input  logic [NUM_LANES-1:0]  opsum_ready_i,
    output logic [NUM_LANES-1:0]  ifmap_pop_o,
    output logic [NUM_LANES-1:0]  ipsum_pop_o,
    output logic [NUM_LANES-1:0]  opsum_push_o,
    output logic                  done_o,
    output logic [31:0]           xfer_total_o
);

    logic all_done;

    lane_cmd_if #(.CNT_W(CNT_W)) cmd_if [NUM_LANES] ();
    lane_stat_if                 stat_if [NUM_LANES] ();

    nl_planner #(
        .NUM_LANES (NUM_LANES),
        .CNT_W     (CNT_W)
    ) nl_planner_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .layer_type_i (layer_type_i),
        .tile_n_i     (tile_n_i),
        .on_real_i    (on_real_i),
        .in_c_i       (in_c_i),
        .pad_r_i      (pad_r_i),
        .pad_l_i      (pad_l_i),
        .out_c_i      (out_c_i),
        .all_done_i   (all_done),
        .done_o       (done_o),
        .cmd          (cmd_if)
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        fifo_lane_ctrl #(
            .CNT_W (CNT_W)
        ) fifo_lane_ctrl_inst (
            .clk           (clk),
            .rst_n         (rst_n),
            .ifmap_valid_i (ifmap_valid_i[k]),
            .ipsum_valid_i (ipsum_valid_i[k]),
            .opsum_ready_i (opsum_ready_i[k]),
            .cmd           (cmd_if[k]),
            .stat          (stat_if[k]),
            .ifmap_pop_o   (ifmap_pop_o[k]),
            .ipsum_pop_o   (ipsum_pop_o[k]),
            .opsum_push_o  (opsum_push_o[k])
        );
    end

    done_gather #(
        .NUM_LANES (NUM_LANES)
    ) done_gather_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .plan_i       (cmd_if[0].plan), // same strobe on every lane
        .stat         (stat_if),
        .all_done_o   (all_done),
        .xfer_total_o (xfer_total_o)
    );

endmodule

// File: bench/tb_l2c_normal_loop.sv
//========================================
// tb_l2c_normal_loop
// random descriptors and ready levels,
// transfers checked against a count model
//========================================
`timescale 1ns/1ns

module tb_l2c_normal_loop;

    localparam int NL      = 8;
    localparam int CW      = l2c_pkg::CNT_W_DEF;
    localparam int TIMEOUT = 400;  // cycles per run

    logic clk, rst_n, start_i, done_o;
    l2c_pkg::layer_type_e layer_type;
    logic [CW-1:0] tile_n, on_real, in_c, out_c;
    logic [1:0]    pad_r, pad_l;
    logic [NL-1:0] ifmap_valid, ipsum_valid, opsum_ready;
    logic [NL-1:0] ifmap_pop, ipsum_pop, opsum_push;
    logic [31:0]   xfer_total;
    logic [31:0]   seed = 32'hc5c5_fb5c;
    int            exp_if [NL];
    int            exp_ip [NL];
    int            exp_op [NL];
    int            exp_total;

    l2c_normal_loop_top #(.NUM_LANES(NL), .CNT_W(CW)) l2c_normal_loop_top_inst (
        .clk(clk), .rst_n(rst_n), .start_i(start_i), .layer_type_i(layer_type),
        .tile_n_i(tile_n), .on_real_i(on_real), .in_c_i(in_c), .pad_r_i(pad_r),
        .pad_l_i(pad_l), .out_c_i(out_c), .ifmap_valid_i(ifmap_valid),
        .ipsum_valid_i(ipsum_valid), .opsum_ready_i(opsum_ready),
        .ifmap_pop_o(ifmap_pop), .ipsum_pop_o(ipsum_pop), .opsum_push_o(opsum_push),
        .done_o(done_o), .xfer_total_o(xfer_total)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int floor0(input int v);
        return (v < 0) ? 0 : v;
    endfunction

    // expected per-lane counts from the layer-type rules
    function automatic void build_model();
        int p;
        p = in_c + pad_r + pad_l;
        exp_total = 0;
        for (int k = 0; k < NL; k++) begin
            exp_if[k] = 0;
            exp_ip[k] = 0;
            exp_op[k] = 0;
            if (layer_type == l2c_pkg::POINTWISE || layer_type == l2c_pkg::LINEAR) begin
                exp_if[k] = floor0(tile_n - 1);
                exp_ip[k] = (k == 0) ? floor0(on_real - 1) : on_real;
                exp_op[k] = on_real;
            end else begin
                if (k < (NL / 3) * 3)
                    exp_if[k] = (layer_type == l2c_pkg::STANDARD) ? floor0(p - 3)
                                                                 : floor0(p - 3 * (k / 3 + 1));
                if (k < NL / 3) begin
                    exp_ip[k] = (k == 0) ? floor0(on_real - 1) : on_real;
                    exp_op[k] = out_c;
                end
            end
            exp_total += exp_if[k] + exp_ip[k] + exp_op[k];
        end
    endfunction

    task automatic check_eq(input string name, input int exp_v, input int act_v);
        assert (exp_v == act_v) else begin
            $display("ERR %s expected %0d actual %0d", name, exp_v, act_v);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic drive_ready();
        ifmap_valid = lcg_next() >> 16;
        ipsum_valid = lcg_next() >> 16;
        opsum_ready = lcg_next() >> 16;
    endtask

    task automatic run_layer(input string name, input bit busy_start);
        int cyc;
        int got_if [NL];
        int got_ip [NL];
        int got_op [NL];
        build_model();
        for (int k = 0; k < NL; k++) begin
            got_if[k] = 0;
            got_ip[k] = 0;
            got_op[k] = 0;
        end
        start_i = 1'b1;
        cyc = 0;
        do begin
            @(negedge clk);
            start_i = busy_start && (cyc == 1);  // extra start while in WAIT_DONE
            drive_ready();
            #1;
            check_eq({name, "_ifmap_gate"}, 0, ifmap_pop & ~ifmap_valid);
            check_eq({name, "_ipsum_gate"}, 0, ipsum_pop & ~ipsum_valid);
            check_eq({name, "_opsum_gate"}, 0, opsum_push & ~opsum_ready);
            for (int k = 0; k < NL; k++) begin
                got_if[k] += ifmap_pop[k];
                got_ip[k] += ipsum_pop[k];
                got_op[k] += opsum_push[k];
            end
            cyc++;
            if (cyc > TIMEOUT) begin
                $display("no done pulse within %0d cycles in run %s", TIMEOUT, name);
                $display("SIMULATION FAILED");
                $fatal(1);
            end
        end while (!done_o);
        for (int k = 0; k < NL; k++) begin
            check_eq($sformatf("%s_lane%0d_ifmap", name, k), exp_if[k], got_if[k]);
            check_eq($sformatf("%s_lane%0d_ipsum", name, k), exp_ip[k], got_ip[k]);
            check_eq($sformatf("%s_lane%0d_opsum", name, k), exp_op[k], got_op[k]);
        end
        check_eq({name, "_total"}, exp_total, xfer_total);
        repeat (3) begin  // done must be a single pulse
            @(negedge clk);
            drive_ready();
            #1;
            check_eq({name, "_done_once"}, 0, done_o);
            check_eq({name, "_idle_strobes"}, 0, ifmap_pop | ipsum_pop | opsum_push);
        end
    endtask

    //========================================
    // test sequence
    //========================================
    initial begin
        rst_n = 1'b0;
        start_i = 1'b0;
        layer_type = l2c_pkg::POINTWISE;
        {tile_n, on_real, in_c, out_c, pad_r, pad_l} = '0;
        {ifmap_valid, ipsum_valid, opsum_ready} = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (6) begin  // quiet after reset
            @(negedge clk);
            drive_ready();
            #1;
            check_eq("reset_strobes", 0, ifmap_pop | ipsum_pop | opsum_push);
            check_eq("reset_done", 0, done_o);
        end
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 6; i++) begin
                @(negedge clk);
                layer_type = l2c_pkg::layer_type_e'(t);
                tile_n  = (i == 0) ? 0 : lcg_next() >> 28;  // run 0 drives counts negative
                on_real = (i == 0) ? 0 : lcg_next() >> 28;
                in_c    = (i == 0) ? 0 : lcg_next() >> 28;
                out_c   = (i == 0) ? 0 : lcg_next() >> 28;
                pad_r   = (i == 0) ? 0 : lcg_next() >> 30;
                pad_l   = (i == 0) ? 0 : lcg_next() >> 30;
                run_layer($sformatf("type%0d_run%0d", t, i), i % 2);
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: all.f
hdl/l2c_pkg.sv
hdl/lane_cmd_if.sv
hdl/lane_stat_if.sv
hdl/nl_planner.sv
hdl/fifo_lane_ctrl.sv
hdl/done_gather.sv
hdl/l2c_normal_loop_top.sv
bench/tb_l2c_normal_loop.sv

// File: Bender.yml
package:
  name: l2c_normal_loop

sources:
  - target: rtl
    files:
      - hdl/l2c_pkg.sv
      - hdl/lane_cmd_if.sv
      - hdl/lane_stat_if.sv
      - hdl/nl_planner.sv
      - hdl/fifo_lane_ctrl.sv
      - hdl/done_gather.sv
      - hdl/l2c_normal_loop_top.sv
  - target: test
    files:
      - bench/tb_l2c_normal_loop.sv
